//--- rtl/fetch_pkg.sv
package fetch_pkg;

    // PC and instruction word width
    localparam int XLEN  = 32;
    localparam int OPC_W = 6;

    ////////////////////
    // Branch opcodes
    ////////////////////
    localparam logic [OPC_W-1:0] OP_JUMP     = 6'h14;
    // Inclusive range of conditional branches
    localparam logic [OPC_W-1:0] OP_BCOND_LO = 6'h16;
    localparam logic [OPC_W-1:0] OP_BCOND_HI = 6'h1B;

    // Word offset widths, scaled by 4 when forming a target
    localparam int COND_OFFS_W = 16;
    localparam int JUMP_OFFS_W = 26;
    localparam int COND_REG_W  = XLEN - OPC_W - COND_OFFS_W;

    // One word, seen either as a conditional branch or as a jump
    typedef union packed {
        struct packed {
            logic [OPC_W-1:0]       opcode;
            logic [COND_OFFS_W-1:0] offset;
            logic [COND_REG_W-1:0]  regs;
        } cond;
        struct packed {
            logic [OPC_W-1:0]       opcode;
            logic [JUMP_OFFS_W-1:0] offset;
        } jump;
    } inst_word_u;

endpackage

//--- rtl/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    ////////////////////
    // Pause vector
    ////////////////////

    // One bit per pipeline stage
    localparam int PAUSE_W = 7;

    // Decode stage
    localparam int PAUSE_ID = 2;

    // Stage after decode
    localparam int PAUSE_EX = 3;

    // A decode pause alone empties the issue slots,
    // a pause of both stages freezes them

endpackage

//--- rtl/branch_predecode.sv
module branch_predecode
    import fetch_pkg::*;
(
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] inst_i,
    output logic            is_branch_o,
    output logic            pred_taken_o,
    output logic [XLEN-1:0] pred_target_o
);

    inst_word_u      word;
    logic            is_jump;
    logic            is_cond;
    logic [XLEN-1:0] jump_offs;
    logic [XLEN-1:0] cond_offs;

    assign word = inst_i;

    ////////////////////
    // Opcode decode
    ////////////////////
    assign is_jump = (word.jump.opcode == OP_JUMP);
    assign is_cond = (word.cond.opcode >= OP_BCOND_LO) &&
                     (word.cond.opcode <= OP_BCOND_HI);

    // Sign extended byte offsets
    assign jump_offs = {{(XLEN - JUMP_OFFS_W - 2){word.jump.offset[JUMP_OFFS_W-1]}},
                        word.jump.offset, 2'b00};
    assign cond_offs = {{(XLEN - COND_OFFS_W - 2){word.cond.offset[COND_OFFS_W-1]}},
                        word.cond.offset, 2'b00};

    ////////////////////
    // Static prediction
    ////////////////////
    always_comb begin
        is_branch_o   = 1'b0;
        pred_taken_o  = 1'b0;
        pred_target_o = '0;
        if (is_jump) begin
            is_branch_o   = 1'b1;
            pred_taken_o  = 1'b1;
            pred_target_o = pc_i + jump_offs;
        end else if (is_cond) begin
            is_branch_o   = 1'b1;
            // Backward branches are assumed to be loops
            pred_taken_o  = word.cond.offset[COND_OFFS_W-1];
            pred_target_o = pc_i + cond_offs;
        end
    end

endmodule

//--- rtl/inst_buffer.sv
module inst_buffer
    import fetch_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       clear_i,
    input  logic                       wr_en_i,
    input  logic [XLEN-1:0]            wr_inst_i,
    input  logic [XLEN-1:0]            wr_pc_i,
    input  logic                       wr_exc_i,
    input  logic                       wr_is_branch_i,
    input  logic                       wr_taken_i,
    input  logic [XLEN-1:0]            wr_target_i,
    input  logic [1:0]                 rd_cnt_i,
    input  logic                       bubble_i,
    input  logic                       hold_i,
    output logic [$clog2(DEPTH):0]     count_o,
    output logic                       inst1_valid_o,
    output logic [XLEN-1:0]            inst1_o,
    output logic [XLEN-1:0]            pc1_o,
    output logic                       exc1_o,
    output logic                       is_branch1_o,
    output logic                       pred_taken1_o,
    output logic [XLEN-1:0]            pred_target1_o,
    output logic                       inst2_valid_o,
    output logic [XLEN-1:0]            inst2_o,
    output logic [XLEN-1:0]            pc2_o,
    output logic                       exc2_o,
    output logic                       is_branch2_o,
    output logic                       pred_taken2_o,
    output logic [XLEN-1:0]            pred_target2_o
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = AW + 1;

    // Entry storage, one array per field
    logic [XLEN-1:0] mem_inst   [DEPTH];
    logic [XLEN-1:0] mem_pc     [DEPTH];
    logic            mem_exc    [DEPTH];
    logic            mem_branch [DEPTH];
    logic            mem_taken  [DEPTH];
    logic [XLEN-1:0] mem_target [DEPTH];

    logic [AW-1:0] head;
    logic [AW-1:0] tail;
    logic [CW-1:0] count;

    // Issue slot registers, index 0 is slot 1
    logic [1:0]      slot_valid;
    logic [XLEN-1:0] slot_inst   [2];
    logic [XLEN-1:0] slot_pc     [2];
    logic            slot_exc    [2];
    logic            slot_branch [2];
    logic            slot_taken  [2];
    logic [XLEN-1:0] slot_target [2];

    ////////////////////
    // Write side
    ////////////////////
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_inst[tail]   <= wr_inst_i;
            mem_pc[tail]     <= wr_pc_i;
            mem_exc[tail]    <= wr_exc_i;
            mem_branch[tail] <= wr_is_branch_i;
            mem_taken[tail]  <= wr_taken_i;
            mem_target[tail] <= wr_target_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (clear_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (wr_en_i) begin
                tail <= tail + 1'b1;
            end
            head  <= head + AW'(rd_cnt_i);
            count <= count + CW'(wr_en_i) - CW'(rd_cnt_i);
        end
    end

    assign count_o = count;

    ////////////////////
    // Read side
    ////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slot_valid <= '0;
        end else if (clear_i || bubble_i) begin
            slot_valid <= '0;
        end else if (!hold_i) begin
            slot_valid <= {rd_cnt_i == 2'd2, rd_cnt_i != 2'd0};
        end
    end

    // Oldest entry goes to slot 1; unloaded slots read as zero
    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (!hold_i) begin
                if (rd_cnt_i > 2'(k)) begin
                    slot_inst[k]   <= mem_inst[head + AW'(k)];
                    slot_pc[k]     <= mem_pc[head + AW'(k)];
                    slot_exc[k]    <= mem_exc[head + AW'(k)];
                    slot_branch[k] <= mem_branch[head + AW'(k)];
                    slot_taken[k]  <= mem_taken[head + AW'(k)];
                    slot_target[k] <= mem_target[head + AW'(k)];
                end else begin
                    slot_inst[k]   <= '0;
                    slot_pc[k]     <= '0;
                    slot_exc[k]    <= 1'b0;
                    slot_branch[k] <= 1'b0;
                    slot_taken[k]  <= 1'b0;
                    slot_target[k] <= '0;
                end
            end
        end
    end

    assign inst1_valid_o  = slot_valid[0];
    assign inst1_o        = slot_inst[0];
    assign pc1_o          = slot_pc[0];
    assign exc1_o         = slot_exc[0];
    assign is_branch1_o   = slot_branch[0];
    assign pred_taken1_o  = slot_taken[0];
    assign pred_target1_o = slot_target[0];

    assign inst2_valid_o  = slot_valid[1];
    assign inst2_o        = slot_inst[1];
    assign pc2_o          = slot_pc[1];
    assign exc2_o         = slot_exc[1];
    assign is_branch2_o   = slot_branch[1];
    assign pred_taken2_o  = slot_taken[1];
    assign pred_target2_o = slot_target[1];

endmodule

//--- rtl/fetch_ctrl.sv
module fetch_ctrl
    import pipe_ctrl_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   fetch_valid_i,
    input  logic                   branch_flush_i,
    input  logic                   exc_flush_i,
    input  logic                   id_stall_i,
    input  logic [PAUSE_W-1:0]     pause_i,
    input  logic                   issue_en_1_i,
    input  logic                   issue_en_2_i,
    input  logic [$clog2(DEPTH):0] count_i,
    output logic                   wr_en_o,
    output logic                   clear_o,
    output logic                   bubble_o,
    output logic                   hold_o,
    output logic [1:0]             rd_cnt_o,
    output logic                   buf_full_o
);

    localparam int CW = $clog2(DEPTH) + 1;

    logic       flush_pend_q;
    logic       flush_now;
    logic       full;
    logic       id_pause;
    logic       ex_pause;
    logic [1:0] req_cnt;

    // Set by reset, so the first cycle out of reset behaves as a flush
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            flush_pend_q <= 1'b1;
        end else begin
            flush_pend_q <= 1'b0;
        end
    end

    assign flush_now  = branch_flush_i | exc_flush_i | flush_pend_q;
    assign full       = (count_i == CW'(DEPTH));
    assign buf_full_o = full;

    ////////////////////
    // Buffer strobes
    ////////////////////
    assign clear_o = flush_now;
    // Wrong path word in the flush cycle is dropped
    assign wr_en_o = fetch_valid_i & ~full & ~flush_now;

    assign id_pause = pause_i[PAUSE_ID];
    assign ex_pause = pause_i[PAUSE_EX];
    assign req_cnt  = {1'b0, issue_en_1_i} + {1'b0, issue_en_2_i};

    always_comb begin
        bubble_o = 1'b0;
        hold_o   = 1'b0;
        rd_cnt_o = 2'd0;
        if (flush_now) begin
            rd_cnt_o = 2'd0;
        end else if (id_pause && ex_pause) begin
            hold_o = 1'b1;
        end else if (id_stall_i || id_pause) begin
            bubble_o = 1'b1;
        end else if (count_i < CW'(req_cnt)) begin
            // Fewer entries than requested
            rd_cnt_o = 2'(count_i);
        end else begin
            rd_cnt_o = req_cnt;
        end
    end

endmodule

//--- rtl/frontend_top.sv
module frontend_top
    import fetch_pkg::*, pipe_ctrl_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               fetch_valid_i,
    input  logic [XLEN-1:0]    fetch_inst_i,
    input  logic [XLEN-1:0]    fetch_pc_i,
    input  logic               fetch_exc_i,
    input  logic               branch_flush_i,
    input  logic               exc_flush_i,
    input  logic               id_stall_i,
    input  logic [PAUSE_W-1:0] pause_i,
    input  logic               issue_en_1_i,
    input  logic               issue_en_2_i,
    output logic               buf_full_o,
    output logic               inst1_valid_o,
    output logic [XLEN-1:0]    inst1_o,
    output logic [XLEN-1:0]    pc1_o,
    output logic               exc1_o,
    output logic               is_branch1_o,
    output logic               pred_taken1_o,
    output logic [XLEN-1:0]    pred_target1_o,
    output logic               inst2_valid_o,
    output logic [XLEN-1:0]    inst2_o,
    output logic [XLEN-1:0]    pc2_o,
    output logic               exc2_o,
    output logic               is_branch2_o,
    output logic               pred_taken2_o,
    output logic [XLEN-1:0]    pred_target2_o
);

    localparam int CW = $clog2(DEPTH) + 1;

    // Predecode results
    logic            is_branch;
    logic            pred_taken;
    logic [XLEN-1:0] pred_target;

    // Control strobes
    logic            wr_en;
    logic            clear;
    logic            bubble;
    logic            hold;
    logic [1:0]      rd_cnt;
    logic [CW-1:0]   count;

    branch_predecode u_predecode (
        .pc_i          (fetch_pc_i),
        .inst_i        (fetch_inst_i),
        .is_branch_o   (is_branch),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target)
    );

    fetch_ctrl #(
        .DEPTH (DEPTH)
    ) u_ctrl (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .fetch_valid_i  (fetch_valid_i),
        .branch_flush_i (branch_flush_i),
        .exc_flush_i    (exc_flush_i),
        .id_stall_i     (id_stall_i),
        .pause_i        (pause_i),
        .issue_en_1_i   (issue_en_1_i),
        .issue_en_2_i   (issue_en_2_i),
        .count_i        (count),
        .wr_en_o        (wr_en),
        .clear_o        (clear),
        .bubble_o       (bubble),
        .hold_o         (hold),
        .rd_cnt_o       (rd_cnt),
        .buf_full_o     (buf_full_o)
    );

    inst_buffer #(
        .DEPTH (DEPTH)
    ) u_buffer (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .clear_i        (clear),
        .wr_en_i        (wr_en),
        .wr_inst_i      (fetch_inst_i),
        .wr_pc_i        (fetch_pc_i),
        .wr_exc_i       (fetch_exc_i),
        .wr_is_branch_i (is_branch),
        .wr_taken_i     (pred_taken),
        .wr_target_i    (pred_target),
        .rd_cnt_i       (rd_cnt),
        .bubble_i       (bubble),
        .hold_i         (hold),
        .count_o        (count),
        .inst1_valid_o  (inst1_valid_o),
        .inst1_o        (inst1_o),
        .pc1_o          (pc1_o),
        .exc1_o         (exc1_o),
        .is_branch1_o   (is_branch1_o),
        .pred_taken1_o  (pred_taken1_o),
        .pred_target1_o (pred_target1_o),
        .inst2_valid_o  (inst2_valid_o),
        .inst2_o        (inst2_o),
        .pc2_o          (pc2_o),
        .exc2_o         (exc2_o),
        .is_branch2_o   (is_branch2_o),
        .pred_taken2_o  (pred_taken2_o),
        .pred_target2_o (pred_target2_o)
    );

endmodule

//--- dv/frontend_properties.sv
module frontend_properties #(
    parameter int DEPTH = 16
) (
    input logic                   clk,
    input logic                   arst_n_i,
    input logic                   clear_i,
    input logic                   wr_en_i,
    input logic [$clog2(DEPTH):0] count_o,
    input logic                   inst1_valid_o,
    input logic                   inst2_valid_o
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CW = $clog2(DEPTH) + 1;

    ////////////////////
    // Occupancy
    ////////////////////
    count_bounded: assert property (@(posedge clk) disable iff (!arst_n_i)
        count_o <= CW'(DEPTH))
        else $error("occupancy above DEPTH");

    // A full buffer takes no write and so never grows
    full_no_rise: assert property (@(posedge clk) disable iff (!arst_n_i)
        (count_o == CW'(DEPTH)) |-> !wr_en_i)
        else $error("write accepted while full");

    ////////////////////
    // Issue slots
    ////////////////////
    slot2_needs_slot1: assert property (@(posedge clk) disable iff (!arst_n_i)
        inst2_valid_o |-> inst1_valid_o)
        else $error("slot 2 valid without slot 1");

    clear_empties_slots: assert property (@(posedge clk) disable iff (!arst_n_i)
        clear_i |=> (!inst1_valid_o && !inst2_valid_o))
        else $error("issue slot valid after clear");

endmodule

bind inst_buffer frontend_properties #(
    .DEPTH (DEPTH)
) u_props (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .clear_i       (clear_i),
    .wr_en_i       (wr_en_i),
    .count_o       (count_o),
    .inst1_valid_o (inst1_valid_o),
    .inst2_valid_o (inst2_valid_o)
);

//--- dv/frontend_tb.sv
module frontend_tb
    import fetch_pkg::*, pipe_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH      = 16;
    localparam int CW         = $clog2(DEPTH) + 1;
    localparam int CLK_PERIOD = 20;
    // Cycle budget of reset and the five tests in order
    localparam int TEST_CYCLES = 10 + 35 + 15 + 40 + 25 + 25;
    localparam int MARGIN      = 100;

    localparam logic [PAUSE_W-1:0] PAUSE_ID_ONLY = PAUSE_W'(1) << PAUSE_ID;
    localparam logic [PAUSE_W-1:0] PAUSE_BOTH    = PAUSE_ID_ONLY | (PAUSE_W'(1) << PAUSE_EX);

    logic                 clk;
    logic                 arst_n_i;
    logic                 fetch_valid_i;
    logic [XLEN-1:0]      fetch_inst_i;
    logic [XLEN-1:0]      fetch_pc_i;
    logic                 fetch_exc_i;
    logic                 branch_flush_i;
    logic                 exc_flush_i;
    logic                 id_stall_i;
    logic [PAUSE_W-1:0]   pause_i;
    logic                 issue_en_1_i;
    logic                 issue_en_2_i;
    logic                 buf_full_o;
    logic                 inst1_valid_o;
    logic [XLEN-1:0]      inst1_o;
    logic [XLEN-1:0]      pc1_o;
    logic                 exc1_o;
    logic                 is_branch1_o;
    logic                 pred_taken1_o;
    logic [XLEN-1:0]      pred_target1_o;
    logic                 inst2_valid_o;
    logic [XLEN-1:0]      inst2_o;
    logic [XLEN-1:0]      pc2_o;
    logic                 exc2_o;
    logic                 is_branch2_o;
    logic                 pred_taken2_o;
    logic [XLEN-1:0]      pred_target2_o;

    // Reference queue with the oldest entry first
    logic [XLEN-1:0] q_inst [$];
    logic [XLEN-1:0] q_pc   [$];
    logic            q_exc  [$];

    integer          seed;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] held_inst;
    logic [XLEN-1:0] held_pc;

    frontend_top #(
        .DEPTH (DEPTH)
    ) dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Watchdog
    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////
    // Checks
    ////////////////////
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error: time %0d ns, %s is %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error: time %0d ns, %s is %b, expected %b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [$clog2(DEPTH):0] got,
                               input logic [$clog2(DEPTH):0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error: time %0d ns, %s is %0d, expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_occupancy(input int n);
        @(negedge clk);
        check_count("count_o", dut.u_buffer.count_o, CW'(n));
        check_bit("buf_full_o", buf_full_o, n == DEPTH);
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Static prediction worked out from the opcode classes
    task automatic predecode_model(input logic [XLEN-1:0] inst, input logic [XLEN-1:0] pc,
                                   output logic br, output logic tk,
                                   output logic [XLEN-1:0] tg);
        inst_word_u w;
        w  = inst;
        br = 1'b0;
        tk = 1'b0;
        tg = '0;
        if (w.jump.opcode == OP_JUMP) begin
            br = 1'b1;
            tk = 1'b1;
            tg = pc + XLEN'($signed(w.jump.offset) * 4);
        end else if (w.cond.opcode >= OP_BCOND_LO && w.cond.opcode <= OP_BCOND_HI) begin
            br = 1'b1;
            tk = ($signed(w.cond.offset) < 0);
            tg = pc + XLEN'($signed(w.cond.offset) * 4);
        end
    endtask

    // Compares one slot with the oldest model entry and then retires it
    task automatic check_entry(input string k, input logic [XLEN-1:0] inst,
                               input logic [XLEN-1:0] pc, input logic exc, input logic br,
                               input logic tk, input logic [XLEN-1:0] tg);
        logic            exp_br;
        logic            exp_tk;
        logic [XLEN-1:0] exp_tg;
        predecode_model(q_inst[0], q_pc[0], exp_br, exp_tk, exp_tg);
        check_word({"inst", k, "_o"}, inst, q_inst[0]);
        check_word({"pc", k, "_o"}, pc, q_pc[0]);
        check_bit({"exc", k, "_o"}, exc, q_exc[0]);
        check_bit({"is_branch", k, "_o"}, br, exp_br);
        check_bit({"pred_taken", k, "_o"}, tk, exp_tk);
        check_word({"pred_target", k, "_o"}, tg, exp_tg);
        void'(q_inst.pop_front());
        void'(q_pc.pop_front());
        void'(q_exc.pop_front());
    endtask

    ////////////////////
    // Stimulus
    ////////////////////
    function automatic logic [XLEN-1:0] rand_word();
        logic [XLEN-1:0] w;
        logic [XLEN-1:0] sel;
        w   = $random(seed);
        sel = $random(seed);
        // Three words in four are steered to branch opcodes
        case (sel[1:0])
            2'd0:       w[XLEN-1 -: OPC_W] = OP_JUMP;
            2'd1, 2'd2: w[XLEN-1 -: OPC_W] = OP_BCOND_LO + OPC_W'(sel[4:2] % 3'd6);
            default:    w = w;
        endcase
        return w;
    endfunction

    task automatic offer_word(input logic [XLEN-1:0] inst, input logic exc, input bit keep);
        @(posedge clk);
        fetch_valid_i <= 1'b1;
        fetch_inst_i  <= inst;
        fetch_pc_i    <= pc_next;
        fetch_exc_i   <= exc;
        if (keep) begin
            q_inst.push_back(inst);
            q_pc.push_back(pc_next);
            q_exc.push_back(exc);
        end
        pc_next = pc_next + 32'd4;
    endtask

    task automatic fetch_idle();
        @(posedge clk);
        fetch_valid_i <= 1'b0;
    endtask

    task automatic write_random(input int n);
        logic [XLEN-1:0] r;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            offer_word(rand_word(), r[0], 1'b1);
        end
        fetch_idle();
    endtask

    // One request checked on the slots after the edge that takes it
    task automatic issue_check(input logic en1, input logic en2);
        int n_req;
        int n_exp;
        n_req = int'(en1) + int'(en2);
        n_exp = (n_req < q_inst.size()) ? n_req : q_inst.size();
        @(posedge clk);
        issue_en_1_i <= en1;
        issue_en_2_i <= en2;
        @(posedge clk);
        issue_en_1_i <= 1'b0;
        issue_en_2_i <= 1'b0;
        @(negedge clk);
        check_bit("inst1_valid_o", inst1_valid_o, n_exp >= 1);
        check_bit("inst2_valid_o", inst2_valid_o, n_exp == 2);
        if (n_exp >= 1) begin
            check_entry("1", inst1_o, pc1_o, exc1_o, is_branch1_o, pred_taken1_o,
                        pred_target1_o);
        end else begin
            check_word("inst1_o", inst1_o, '0);
        end
        if (n_exp == 2) begin
            check_entry("2", inst2_o, pc2_o, exc2_o, is_branch2_o, pred_taken2_o,
                        pred_target2_o);
        end else begin
            check_word("inst2_o", inst2_o, '0);
        end
    endtask

    // Flush while a dual request and a wrong path word are both pending
    task automatic flush_cycle(input logic br_flush, input logic ex_flush);
        @(posedge clk);
        branch_flush_i <= br_flush;
        exc_flush_i    <= ex_flush;
        issue_en_1_i   <= 1'b1;
        issue_en_2_i   <= 1'b1;
        fetch_valid_i  <= 1'b1;
        fetch_inst_i   <= rand_word();
        @(posedge clk);
        branch_flush_i <= 1'b0;
        exc_flush_i    <= 1'b0;
        issue_en_1_i   <= 1'b0;
        issue_en_2_i   <= 1'b0;
        fetch_valid_i  <= 1'b0;
        @(negedge clk);
        check_bit("inst1_valid_o", inst1_valid_o, 1'b0);
        check_bit("inst2_valid_o", inst2_valid_o, 1'b0);
        check_count("count_o", dut.u_buffer.count_o, '0);
        q_inst.delete();
        q_pc.delete();
        q_exc.delete();
    endtask

    // Dual request under stall or pause that must not drain the buffer
    task automatic blocked_request(input logic stall, input logic [PAUSE_W-1:0] pv,
                                   input int n_held);
        @(posedge clk);
        id_stall_i   <= stall;
        pause_i      <= pv;
        issue_en_1_i <= 1'b1;
        issue_en_2_i <= 1'b1;
        @(posedge clk);
        id_stall_i   <= 1'b0;
        pause_i      <= '0;
        issue_en_1_i <= 1'b0;
        issue_en_2_i <= 1'b0;
        @(negedge clk);
        check_bit("inst1_valid_o", inst1_valid_o, 1'b0);
        check_bit("inst2_valid_o", inst2_valid_o, 1'b0);
        check_count("count_o", dut.u_buffer.count_o, CW'(n_held));
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic test_single_issue();
        write_random(10);
        check_occupancy(10);
        for (int i = 0; i < 10; i++) begin
            issue_check(1'b1, 1'b0);
        end
        check_occupancy(0);
    endtask

    task automatic test_dual_issue();
        write_random(3);
        issue_check(1'b1, 1'b1);
        issue_check(1'b1, 1'b1);
        // Buffer is empty now
        issue_check(1'b1, 1'b1);
    endtask

    task automatic test_full();
        write_random(DEPTH);
        check_occupancy(DEPTH);
        // Offered against the full flag and therefore lost
        offer_word(rand_word(), 1'b0, 1'b0);
        fetch_idle();
        check_occupancy(DEPTH);
        for (int i = 0; i < DEPTH / 2; i++) begin
            issue_check(1'b1, 1'b1);
        end
        check_occupancy(0);
    endtask

    task automatic test_flush();
        write_random(4);
        flush_cycle(1'b1, 1'b0);
        write_random(3);
        flush_cycle(1'b0, 1'b1);
        write_random(3);
        issue_check(1'b1, 1'b1);
        issue_check(1'b1, 1'b0);
        check_occupancy(0);
    endtask

    task automatic test_stall_pause();
        write_random(4);
        blocked_request(1'b1, '0, 4);
        blocked_request(1'b0, PAUSE_ID_ONLY, 4);
        held_inst = q_inst[0];
        held_pc   = q_pc[0];
        @(posedge clk);
        issue_en_1_i <= 1'b1;
        @(posedge clk);
        pause_i      <= PAUSE_BOTH;
        issue_en_2_i <= 1'b1;
        @(negedge clk);
        check_bit("inst1_valid_o", inst1_valid_o, 1'b1);
        check_entry("1", inst1_o, pc1_o, exc1_o, is_branch1_o, pred_taken1_o, pred_target1_o);
        @(posedge clk);
        pause_i      <= '0;
        issue_en_1_i <= 1'b0;
        issue_en_2_i <= 1'b0;
        // Slot 1 frozen through the hold edge
        @(negedge clk);
        check_bit("inst1_valid_o", inst1_valid_o, 1'b1);
        check_bit("inst2_valid_o", inst2_valid_o, 1'b0);
        check_word("inst1_o", inst1_o, held_inst);
        check_word("pc1_o", pc1_o, held_pc);
        check_count("count_o", dut.u_buffer.count_o, CW'(3));
        issue_check(1'b1, 1'b1);
        issue_check(1'b1, 1'b0);
        check_occupancy(0);
    endtask

    initial begin
        seed           = 32'h35812344;
        pc_next        = 32'h0000_1000;
        arst_n_i       = 1'b0;
        fetch_valid_i  = 1'b0;
        fetch_inst_i   = '0;
        fetch_pc_i     = '0;
        fetch_exc_i    = 1'b0;
        branch_flush_i = 1'b0;
        exc_flush_i    = 1'b0;
        id_stall_i     = 1'b0;
        pause_i        = '0;
        issue_en_1_i   = 1'b0;
        issue_en_2_i   = 1'b0;
        repeat (8) @(posedge clk);
        arst_n_i <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_bit("inst1_valid_o", inst1_valid_o, 1'b0);
        check_bit("inst2_valid_o", inst2_valid_o, 1'b0);
        check_bit("buf_full_o", buf_full_o, 1'b0);
        test_single_issue();
        test_dual_issue();
        test_full();
        test_flush();
        test_stall_pause();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- all.f
rtl/fetch_pkg.sv
rtl/pipe_ctrl_pkg.sv
rtl/branch_predecode.sv
rtl/inst_buffer.sv
rtl/fetch_ctrl.sv
rtl/frontend_top.sv
dv/frontend_properties.sv
dv/frontend_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module frontend_tb -f all.f -o frontend_sim

./obj_dir/frontend_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation OK"
